// File: common/motion_pkg.sv
package motion_pkg;

  localparam int CHAN_W = 5;                           // Camera channel depth
  localparam int OUT_W  = 10;                          // VGA DAC channel depth

  // Brightness cut for the binary method, compared against r+g+b
  localparam int BIN_THRESHOLD = 48;                   // Bright when sum is above this

  localparam logic [OUT_W-1:0] MARK_LEVEL = '1;        // Full-scale red for the mark

  // One camera pixel, RGB555
  typedef struct packed {
    logic [CHAN_W-1:0] r;                              // Red
    logic [CHAN_W-1:0] g;                              // Green
    logic [CHAN_W-1:0] b;                              // Blue
  } rgb555_t;

  // Same raster position in two consecutive frames
  typedef struct packed {
    rgb555_t cur;                                      // Current frame
    rgb555_t prev;                                     // Previous frame
  } pix_pair_t;

  // Output pixel at VGA depth
  typedef struct packed {
    logic [OUT_W-1:0] r;                               // Red, may carry the mark
    logic [OUT_W-1:0] g;                               // Green
    logic [OUT_W-1:0] b;                               // Blue
  } vga_rgb_t;

endpackage

// File: motion/frame_compare.sv
module frame_compare (
  input  logic                  iCLK_50,
  input  logic                  arst_n,
  input  logic                  pix_valid,             // Advance strobe
  input  motion_pkg::pix_pair_t pix_in,                // Current and previous pixel
  output logic                  diff_bit,              // Method one raw bit
  output logic                  bin_bit                // Method two raw bit
);

  logic chan_diff;                                     // Any channel changed
  logic cur_bright;
  logic prev_bright;

  // Channel sum against the threshold, sum of three 5-bit values fits in 7 bits
  function automatic logic is_bright(motion_pkg::rgb555_t p);
    logic [6:0] sum;
    sum = 7'(p.r) + 7'(p.g) + 7'(p.b);
    return sum > 7'(motion_pkg::BIN_THRESHOLD);
  endfunction

  // Method one: per-channel XOR, then OR across channels
  assign chan_diff = (|(pix_in.cur.r ^ pix_in.prev.r)) |
                     (|(pix_in.cur.g ^ pix_in.prev.g)) |
                     (|(pix_in.cur.b ^ pix_in.prev.b));

  // Method two: binarize each frame separately
  assign cur_bright  = is_bright(pix_in.cur);
  assign prev_bright = is_bright(pix_in.prev);

  always_ff @(posedge iCLK_50 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      diff_bit <= 1'b0;
      bin_bit  <= 1'b0;
    end
    else if (pix_valid)                                // Only real pixels enter
    begin
      diff_bit <= chan_diff;
      bin_bit  <= cur_bright ^ prev_bright;            // Brightness flipped between frames
    end
  end

endmodule

// File: motion/window_filter.sv
module window_filter #(
  parameter int LINE_WIDTH = 640,                      // Pixels per line
  parameter int WINDOW     = 11,                       // Square window edge
  parameter bit DILATE     = 1'b0                      // 0 erode, 1 dilate
) (
  input  logic iCLK_50,
  input  logic arst_n,
  input  logic advance,                                // Shift and evaluate
  input  logic bit_in,                                 // Newest stream bit
  output logic bit_out                                 // Window result
);

  // Oldest tap sits WINDOW-1 lines and WINDOW-1 pixels back
  localparam int DEPTH = (WINDOW - 1) * LINE_WIDTH + (WINDOW - 1);
  localparam int TAPS  = WINDOW * WINDOW;

  logic [DEPTH-1:0] hist;                              // hist[k] is bit k+1 pixels back
  logic [DEPTH:0]   full;                              // full[k] is bit k pixels back
  logic [TAPS-1:0]  taps;                              // Window picks
  logic             window_hit;

  assign full = {hist, bit_in};                        // Incoming bit at offset 0

  // Gather the WINDOW x WINDOW grid, rows are one line apart
  always_comb
  begin
    for (int r = 0; r < WINDOW; r++)
    begin
      for (int c = 0; c < WINDOW; c++)
      begin
        taps[r*WINDOW + c] = full[r*LINE_WIDTH + c];
      end
    end
  end

  assign window_hit = DILATE ? (|taps) : (&taps);      // OR for dilate, AND for erode

  always_ff @(posedge iCLK_50 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      hist    <= '0;                                   // Empty history reads as no motion
      bit_out <= 1'b0;
    end
    else if (advance)
    begin
      bit_out <= window_hit;
      hist    <= {hist[DEPTH-2:0], bit_in};            // Stream wraps across line ends
    end
  end

endmodule

// File: motion/motion_detect.sv
module motion_detect #(
  parameter int LINE_WIDTH = 640,
  parameter int WINDOW     = 11
) (
  input  logic                  iCLK_50,
  input  logic                  arst_n,
  input  logic                  pix_valid,
  input  motion_pkg::pix_pair_t pix_in,
  output logic                  motion                 // Either method fired
);

  logic diff_bit;                                      // Raw change bit
  logic bin_bit;                                       // Raw binary flip bit
  logic diff_ero;                                      // Method one after erode
  logic diff_dil;                                      // Method one after dilate
  logic bin_ero;                                       // Method two after erode
  logic bin_dly;                                       // Method two, one valid later

  frame_compare u_compare (
    .iCLK_50   (iCLK_50),
    .arst_n    (arst_n),
    .pix_valid (pix_valid),
    .pix_in    (pix_in),
    .diff_bit  (diff_bit),
    .bin_bit   (bin_bit)
  );

  // Method one, erode drops speckle, dilate grows what survives
  window_filter #(.LINE_WIDTH(LINE_WIDTH), .WINDOW(WINDOW), .DILATE(1'b0)) u_diff_erode (
    .iCLK_50 (iCLK_50),
    .arst_n  (arst_n),
    .advance (pix_valid),
    .bit_in  (diff_bit),
    .bit_out (diff_ero)
  );

  window_filter #(.LINE_WIDTH(LINE_WIDTH), .WINDOW(WINDOW), .DILATE(1'b1)) u_diff_dilate (
    .iCLK_50 (iCLK_50),
    .arst_n  (arst_n),
    .advance (pix_valid),
    .bit_in  (diff_ero),
    .bit_out (diff_dil)
  );

  // Method two, a single erode
  window_filter #(.LINE_WIDTH(LINE_WIDTH), .WINDOW(WINDOW), .DILATE(1'b0)) u_bin_erode (
    .iCLK_50 (iCLK_50),
    .arst_n  (arst_n),
    .advance (pix_valid),
    .bit_in  (bin_bit),
    .bit_out (bin_ero)
  );

  // One stage shorter than method one, so pad it by a valid
  always_ff @(posedge iCLK_50 or negedge arst_n)
  begin
    if (!arst_n)
      bin_dly <= 1'b0;
    else if (pix_valid)
      bin_dly <= bin_ero;
  end

  assign motion = diff_dil | bin_dly;                  // Both now describe the same pixel

endmodule

// File: logic/overlay_mark.sv
module overlay_mark #(
  parameter int LINE_WIDTH  = 640,
  parameter int FRAME_LINES = 480,
  parameter int MARGIN      = 20                       // Unmarked border width
) (
  input  logic                  iCLK_50,
  input  logic                  arst_n,
  input  logic                  pix_valid,
  input  motion_pkg::pix_pair_t pix_in,
  input  logic                  motion,
  output motion_pkg::vga_rgb_t  pix_out,
  output logic                  out_valid
);

  localparam int XW  = $clog2(LINE_WIDTH);
  localparam int YW  = $clog2(FRAME_LINES);
  localparam int PAD = motion_pkg::OUT_W - motion_pkg::CHAN_W;    // Low zero bits

  logic [XW-1:0] x_cnt;                                // Column of the arriving pixel
  logic [YW-1:0] y_cnt;                                // Line of the arriving pixel
  logic          in_box;
  logic          x_last;

  assign x_last = (x_cnt == XW'(LINE_WIDTH - 1));

  // Marked region, same shape as the reference box
  assign in_box = (int'(x_cnt) >= MARGIN) && (int'(x_cnt) < LINE_WIDTH - MARGIN) &&
                  (int'(y_cnt) >= MARGIN) && (int'(y_cnt) < FRAME_LINES - MARGIN);

  // Raster position from the valid count
  always_ff @(posedge iCLK_50 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      x_cnt <= '0;
      y_cnt <= '0;
    end
    else if (pix_valid)
    begin
      if (x_last)
      begin
        x_cnt <= '0;
        if (y_cnt == YW'(FRAME_LINES - 1))             // Frame wrap
          y_cnt <= '0;
        else
          y_cnt <= y_cnt + 1'b1;
      end
      else
        x_cnt <= x_cnt + 1'b1;
    end
  end

  always_ff @(posedge iCLK_50 or negedge arst_n)
  begin
    if (!arst_n)
      out_valid <= 1'b0;
    else
      out_valid <= pix_valid;                          // One pulse per pixel
  end

  // Widen to VGA depth, red overridden inside the box on motion
  always_ff @(posedge iCLK_50)
  begin
    if (pix_valid)
    begin
      pix_out.g <= {pix_in.cur.g, {PAD{1'b0}}};
      pix_out.b <= {pix_in.cur.b, {PAD{1'b0}}};
      if (in_box && motion)
        pix_out.r <= motion_pkg::MARK_LEVEL;
      else
        pix_out.r <= {pix_in.cur.r, {PAD{1'b0}}};
    end
  end

endmodule

// File: logic/alarm_tone.sv
module alarm_tone #(
  parameter int ALARM_CYCLES = 2**24,                  // Hold time after last motion
  parameter int TONE_BIT     = 21                      // Divider tap for the tone
) (
  input  logic iCLK_50,
  input  logic arst_n,
  input  logic motion,
  output logic alarm,
  output logic tone                                    // Square wave while alarmed
);

  localparam int HW = $clog2(ALARM_CYCLES + 1);        // Room for the saturated value

  logic [HW-1:0]       hold_cnt;                       // Cycles since last motion
  logic [TONE_BIT:0]   tone_cnt;                       // Free-running divider

  // Restart on motion, count up to the limit and stop there
  always_ff @(posedge iCLK_50 or negedge arst_n)
  begin
    if (!arst_n)
      hold_cnt <= HW'(ALARM_CYCLES);                   // Quiet at power-up
    else if (motion)
      hold_cnt <= '0;
    else if (hold_cnt < HW'(ALARM_CYCLES))
      hold_cnt <= hold_cnt + 1'b1;
  end

  always_ff @(posedge iCLK_50 or negedge arst_n)
  begin
    if (!arst_n)
      tone_cnt <= '0;
    else
      tone_cnt <= tone_cnt + 1'b1;
  end

  assign alarm = (hold_cnt < HW'(ALARM_CYCLES));       // Still inside hold time
  assign tone  = alarm & tone_cnt[TONE_BIT];           // Gated divider output

endmodule

// File: logic/motion_top.sv
module motion_top #(
  parameter int LINE_WIDTH   = 640,
  parameter int FRAME_LINES  = 480,
  parameter int MARGIN       = 20,
  parameter int WINDOW       = 11,
  parameter int ALARM_CYCLES = 2**24,
  parameter int TONE_BIT     = 21
) (
  input  logic                  iCLK_50,
  input  logic                  arst_n,
  input  logic                  pix_valid,             // One pixel pair per strobe
  input  motion_pkg::pix_pair_t pix_in,
  output motion_pkg::vga_rgb_t  pix_out,
  output logic                  out_valid,
  output logic                  motion,
  output logic                  alarm,
  output logic                  tone
);

  // Detection pipeline
  motion_detect #(
    .LINE_WIDTH (LINE_WIDTH),
    .WINDOW     (WINDOW)
  ) u_detect (
    .iCLK_50   (iCLK_50),
    .arst_n    (arst_n),
    .pix_valid (pix_valid),
    .pix_in    (pix_in),
    .motion    (motion)
  );

  // Red mark on the video path
  overlay_mark #(
    .LINE_WIDTH  (LINE_WIDTH),
    .FRAME_LINES (FRAME_LINES),
    .MARGIN      (MARGIN)
  ) u_overlay (
    .iCLK_50   (iCLK_50),
    .arst_n    (arst_n),
    .pix_valid (pix_valid),
    .pix_in    (pix_in),
    .motion    (motion),
    .pix_out   (pix_out),
    .out_valid (out_valid)
  );

  // Speaker side
  alarm_tone #(
    .ALARM_CYCLES (ALARM_CYCLES),
    .TONE_BIT     (TONE_BIT)
  ) u_alarm (
    .iCLK_50 (iCLK_50),
    .arst_n  (arst_n),
    .motion  (motion),
    .alarm   (alarm),
    .tone    (tone)
  );

endmodule

// File: test/motion_model.svh
`ifndef MOTION_MODEL_SVH
`define MOTION_MODEL_SVH

  localparam int         MAX_PIX      = 8192;         // Longest valid stream modelled
  localparam int         BRIGHT_ABOVE = 48;           // Channel sum cut
  localparam logic [9:0] MODEL_MARK   = 10'h3ff;      // Full red

  bit diff_hist [MAX_PIX];                             // Any channel changed
  bit bin_hist  [MAX_PIX];                             // Brightness flipped
  bit ero_hist  [MAX_PIX];                             // Eroded change map
  bit mot_hist  [MAX_PIX];                             // E(n) or M(n)

  function automatic bit pixel_bright(motion_pkg::rgb555_t p);
    int sum;
    sum = int'(p.r) + int'(p.g) + int'(p.b);
    return sum > BRIGHT_ABOVE;
  endfunction

  // Before pixel 0 everything reads as zero
  function automatic bit hist_bit(int which, int idx);
    if (idx < 0)
      return 1'b0;
    case (which)
      0:       return diff_hist[idx];
      1:       return bin_hist[idx];
      default: return ero_hist[idx];
    endcase
  endfunction

  // AND over the window for erode, OR for dilate
  function automatic bit window_reduce(int which, int n, bit any_mode);
    bit acc;
    acc = !any_mode;
    for (int r = 0; r < TB_WINDOW; r++)
    begin
      for (int c = 0; c < TB_WINDOW; c++)
      begin
        if (any_mode)
          acc = acc | hist_bit(which, n - r * TB_LINE_WIDTH - c);
        else
          acc = acc & hist_bit(which, n - r * TB_LINE_WIDTH - c);
      end
    end
    return acc;
  endfunction

  function automatic void model_push(int n, motion_pkg::pix_pair_t p);
    diff_hist[n] = (p.cur != p.prev);
    bin_hist[n]  = pixel_bright(p.cur) ^ pixel_bright(p.prev);
    ero_hist[n]  = window_reduce(0, n, 1'b0);
    mot_hist[n]  = window_reduce(2, n, 1'b1) | window_reduce(1, n, 1'b0);
  endfunction

  // Flag after count valids describes pixel count-3
  function automatic bit model_motion(int count);
    if (count < 3)
      return 1'b0;
    return mot_hist[count - 3];
  endfunction

  function automatic bit in_margin_box(int n);
    int x;
    int y;
    x = n % TB_LINE_WIDTH;
    y = (n / TB_LINE_WIDTH) % TB_FRAME_LINES;
    return x >= TB_MARGIN && x < TB_LINE_WIDTH - TB_MARGIN &&
           y >= TB_MARGIN && y < TB_FRAME_LINES - TB_MARGIN;
  endfunction

  function automatic motion_pkg::vga_rgb_t widen_pixel(motion_pkg::rgb555_t p, bit mark);
    motion_pkg::vga_rgb_t v;
    v.r = mark ? MODEL_MARK : {p.r, 5'b0};
    v.g = {p.g, 5'b0};
    v.b = {p.b, 5'b0};
    return v;
  endfunction

`endif

// File: test/tb_motion_top.sv
module tb_motion_top;

  localparam int TB_LINE_WIDTH   = 16;
  localparam int TB_FRAME_LINES  = 12;
  localparam int TB_MARGIN       = 2;
  localparam int TB_WINDOW       = 3;
  localparam int TB_ALARM_CYCLES = 200;
  localparam int TB_TONE_BIT     = 3;

  logic                  iCLK_50;
  logic                  arst_n;
  logic                  pix_valid;
  motion_pkg::pix_pair_t pix_in;
  motion_pkg::vga_rgb_t  pix_out;
  logic                  out_valid;
  logic                  motion;
  logic                  alarm;
  logic                  tone;

  integer                seed          = 32'ha35ceebd;
  int                    vcount        = 0;               // Valids taken by the DUT
  logic                  pend_valid    = 1'b0;            // Taken at the next edge
  motion_pkg::pix_pair_t pend_pix      = '0;
  logic                  last_motion   = 1'b0;            // Motion in the previous cycle
  logic                  last_alarm    = 1'b0;
  int                    hold_model    = TB_ALARM_CYCLES; // Starts saturated
  int                    tick_model    = 0;               // Edges since reset release
  int                    quiet_high    = 0;               // Alarm cycles since last motion
  int                    alarm_falls   = 0;
  bit                    tone_on_seen  = 1'b0;
  bit                    tone_off_seen = 1'b0;
  bit                    motion_seen   = 1'b0;

  `include "motion_model.svh"

  motion_top #(
    .LINE_WIDTH   (TB_LINE_WIDTH),
    .FRAME_LINES  (TB_FRAME_LINES),
    .MARGIN       (TB_MARGIN),
    .WINDOW       (TB_WINDOW),
    .ALARM_CYCLES (TB_ALARM_CYCLES),
    .TONE_BIT     (TB_TONE_BIT)
  ) uut (
    .iCLK_50   (iCLK_50),
    .arst_n    (arst_n),
    .pix_valid (pix_valid),
    .pix_in    (pix_in),
    .pix_out   (pix_out),
    .out_valid (out_valid),
    .motion    (motion),
    .alarm     (alarm),
    .tone      (tone)
  );

  initial
  begin
    iCLK_50 = 1'b0;
    forever #5 iCLK_50 = ~iCLK_50;
  end

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (actual !== expected)
    begin
      stop_with_failure($sformatf("CHECK FAILED %s expected %0h actual %0h",
                                  name, expected, actual));
    end
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic motion_pkg::rgb555_t level_pixel(input bit bright);
    motion_pkg::rgb555_t p;
    p.r = 5'(bright ? 17 + rand_below(15) : rand_below(16));   // Sum stays off the cut
    p.g = 5'(bright ? 17 + rand_below(15) : rand_below(16));
    p.b = 5'(bright ? 17 + rand_below(15) : rand_below(16));
    return p;
  endfunction

  // Mode 0 quiet, 1 changed pixels, 2 bright/dark flips
  function automatic motion_pkg::pix_pair_t make_pair(input int mode);
    motion_pkg::pix_pair_t pp;
    bit                    swap;
    pp.cur  = motion_pkg::rgb555_t'(15'(rand_below(32768)));
    pp.prev = pp.cur;
    if (mode == 0 && rand_below(64) == 0)
      pp.prev = motion_pkg::rgb555_t'(pp.cur ^ 15'h0421);       // Lone speckle
    else if (mode == 1 && rand_below(8) != 0)
      pp.prev = motion_pkg::rgb555_t'(pp.cur ^ 15'(1 + rand_below(32767)));
    else if (mode == 2 && rand_below(16) != 0)
    begin
      swap    = (rand_below(2) == 1);
      pp.cur  = level_pixel(!swap);
      pp.prev = level_pixel(swap);
    end
    return pp;
  endfunction

  // The edge just passed took pend_valid and pend_pix
  task automatic check_cycle();
    bit exp_alarm;
    bit mark;
    tick_model++;
    if (last_motion)
      hold_model = 0;
    else if (hold_model < TB_ALARM_CYCLES)
      hold_model++;
    compare_value("out_valid", 64'(pend_valid), 64'(out_valid));
    if (pend_valid)
    begin
      if (vcount >= MAX_PIX)
        stop_with_failure("Stimulus ran past the length of the model history");
      model_push(vcount, pend_pix);
      mark = last_motion && in_margin_box(vcount);
      compare_value("pix_out", 64'(widen_pixel(pend_pix.cur, mark)), 64'(pix_out));
      vcount++;
    end
    compare_value("motion", 64'(model_motion(vcount)), 64'(motion));
    exp_alarm = (hold_model < TB_ALARM_CYCLES);
    compare_value("alarm", 64'(exp_alarm), 64'(alarm));
    compare_value("tone", 64'(exp_alarm & tick_model[TB_TONE_BIT]), 64'(tone));
    if (motion)
      quiet_high = 0;
    else if (alarm)
      quiet_high++;
    if (last_alarm && !alarm)
    begin
      alarm_falls++;
      compare_value("alarm hold length", 64'(TB_ALARM_CYCLES), 64'(quiet_high));
    end
    if (alarm && tone)
      tone_on_seen = 1'b1;
    if (alarm && !tone)
      tone_off_seen = 1'b1;
    motion_seen = motion_seen | motion;
    last_motion = motion;
    last_alarm  = alarm;
    pend_valid  = pix_valid;
    pend_pix    = pix_in;
  endtask

  task automatic step(input logic valid, input motion_pkg::pix_pair_t pp);
    @(posedge iCLK_50);
    pix_valid <= valid;
    pix_in    <= pp;
    @(negedge iCLK_50);                                 // Outputs settled mid-cycle
    check_cycle();
  endtask

  task automatic run_cycles(input int mode, input int cycles);
    for (int i = 0; i < cycles; i++)
      step(rand_below(4) != 0, make_pair(mode));
  endtask

  task automatic run_pixels(input int mode, input int count);
    int  sent;
    int  cycles;
    bit  v;
    sent   = 0;
    cycles = 0;
    while (sent < count)
    begin
      if (cycles > 8 * count)
        stop_with_failure("Burst did not deliver its pixels in time");
      v = (rand_below(4) != 0);                        // Random gaps
      step(v, make_pair(mode));
      cycles++;
      if (v)
        sent++;
    end
  endtask

  task automatic wait_alarm_clear();
    int waited;
    waited = 0;
    while (alarm)
    begin
      if (waited >= 2 * TB_ALARM_CYCLES)
        stop_with_failure("Alarm stayed on long after motion stopped");
      step(rand_below(4) != 0, make_pair(0));
      waited++;
    end
  endtask

  initial
  begin
    arst_n    = 1'b0;
    pix_valid = 1'b0;
    pix_in    = '0;
    repeat (4) @(posedge iCLK_50);
    arst_n <= 1'b1;
    @(negedge iCLK_50);
    compare_value("reset out_valid", 64'(0), 64'(out_valid));
    compare_value("reset motion", 64'(0), 64'(motion));
    compare_value("reset alarm", 64'(0), 64'(alarm));
    compare_value("reset tone", 64'(0), 64'(tone));
    pend_valid = pix_valid;
    pend_pix   = pix_in;
    for (int round = 0; round < 6; round++)
    begin
      run_cycles(0, 10 + rand_below(40));
      run_pixels(1 + round % 2, (3 + rand_below(3)) * TB_LINE_WIDTH);
      run_cycles(0, TB_ALARM_CYCLES + 60);             // Long quiet stretch
      wait_alarm_clear();
    end
    if (!motion_seen)
      stop_with_failure("Motion flag never rose during the bursts");
    else if (alarm_falls == 0)
      stop_with_failure("Alarm never timed out");
    else if (!(tone_on_seen && tone_off_seen))
      stop_with_failure("Tone was not seen both on and off while alarmed");
    else
    begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// File: all.f
+incdir+test
common/motion_pkg.sv
motion/frame_compare.sv
motion/window_filter.sv
motion/motion_detect.sv
logic/overlay_mark.sv
logic/alarm_tone.sv
logic/motion_top.sv
test/tb_motion_top.sv

// File: Makefile
# Verilator build and run of the motion detection testbench

VERILATOR ?= verilator
TOP       ?= tb_motion_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := test/motion_model.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
